/* hw/soc_ifc_settings.svh */
`ifndef SOC_IFC_SETTINGS_SVH
`define SOC_IFC_SETTINGS_SVH

// number of fuse words in the bank
// this also sets the size of the fuse address window
`define SOC_IFC_FUSE_WORDS 4

// bits per fuse word
// must match the axi data width
`define SOC_IFC_FUSE_WIDTH 32

// reset value of the firmware-update reset wait register
// counted in clk cycles
`define SOC_IFC_FW_RST_WAIT_DEFAULT 8'd20

`endif

/* hw/soc_ifc_pkg.sv */
`default_nettype none

`include "soc_ifc_settings.svh"

package soc_ifc_pkg;

    // boot sequencer states
    typedef enum logic [2:0] {
        BOOT_IDLE   = 3'd0,
        BOOT_FUSE   = 3'd1,
        BOOT_FW_RST = 3'd2,
        BOOT_WAIT   = 3'd3,
        BOOT_DONE   = 3'd4
    } boot_fsm_state_e;

    // firmware-update reset wait count
    typedef logic [7:0] wait_cycles_t;

    // register port address and data
    typedef logic [11:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;

    // one fuse word
    typedef logic [`SOC_IFC_FUSE_WIDTH-1:0] fuse_word_t;

    // register map
    localparam axil_addr_t ADDR_STATUS        = 12'h000;
    localparam axil_addr_t ADDR_FUSE_DONE     = 12'h004;
    localparam axil_addr_t ADDR_FW_UPDATE_RST = 12'h008;
    localparam axil_addr_t ADDR_FW_RST_WAIT   = 12'h00C;
    localparam axil_addr_t ADDR_FUSE_BASE     = 12'h100;

    // axi response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // manager to subordinate
    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        logic [3:0] wstrb;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    // subordinate to manager
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        logic [1:0] rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

/* hw/soc_ifc_boot_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module soc_ifc_boot_fsm
    import soc_ifc_pkg::*;
(
    input  logic         clk,
    input  logic         cptra_rst_b,
    input  logic         cptra_pwrgood,
    input  logic         fw_update_rst,
    input  wait_cycles_t fw_update_rst_wait_cycles,
    input  logic         fuse_done,
    output logic         ready_for_fuses,
    // global reset for everything outside the core
    output logic         cptra_noncore_rst_b,
    // global plus firmware-update reset, core only
    output logic         cptra_uc_rst_b,
    output logic         iccm_unlock
);

    boot_fsm_state_e boot_fsm_ps;
    boot_fsm_state_e boot_fsm_ns;

    // state transition arcs
    logic arc_idle_fuse;
    logic arc_fuse_done;
    logic arc_done_fw_rst;
    logic arc_wait_done;

    // reset release controls
    logic propagate_reset_en;
    logic fsm_synch_noncore_rst_b;
    logic fsm_synch_uc_rst_b;
    logic synch_uc_rst_b;

    logic         fsm_iccm_unlock;
    wait_cycles_t wait_count;
    logic         wait_count_load;
    logic         wait_count_decr;

    // power is good, open the fuse window
    assign arc_idle_fuse   = cptra_pwrgood;
    // soc agent finished loading fuses
    assign arc_fuse_done   = fuse_done;
    // firmware asked for a core-only reset
    assign arc_done_fw_rst = fw_update_rst;
    // wait period over
    assign arc_wait_done   = (wait_count == '0);

    always_comb begin
        boot_fsm_ns           = boot_fsm_ps;
        ready_for_fuses       = 1'b0;
        propagate_reset_en    = 1'b0;
        // core held in reset unless the fsm says otherwise
        fsm_synch_uc_rst_b    = 1'b0;
        fsm_iccm_unlock       = 1'b0;
        // counter follows the wait register while idle
        wait_count_load       = 1'b1;
        wait_count_decr       = 1'b0;

        unique case (boot_fsm_ps)
            BOOT_IDLE: begin
                if (arc_idle_fuse) begin
                    boot_fsm_ns = BOOT_FUSE;
                end
            end
            BOOT_FUSE: begin
                ready_for_fuses = 1'b1;
                if (arc_fuse_done) begin
                    boot_fsm_ns = BOOT_DONE;
                end
            end
            BOOT_FW_RST: begin
                // one cycle to pull the core reset, then wait
                boot_fsm_ns     = BOOT_WAIT;
                wait_count_load = 1'b0;
                wait_count_decr = 1'b1;
            end
            BOOT_WAIT: begin
                wait_count_load = 1'b0;
                wait_count_decr = 1'b1;
                // unlock only at the very end of the reset flow,
                // so the iccm cannot be touched while the core restarts
                if (arc_wait_done) begin
                    boot_fsm_ns     = BOOT_DONE;
                    fsm_iccm_unlock = 1'b1;
                end
            end
            BOOT_DONE: begin
                if (arc_done_fw_rst) begin
                    boot_fsm_ns = BOOT_FW_RST;
                end
                // let reset release flow through the sync stages
                propagate_reset_en    = 1'b1;
                fsm_synch_uc_rst_b    = 1'b1;
            end
            default: begin
                boot_fsm_ns = BOOT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            boot_fsm_ps             <= BOOT_IDLE;
            fsm_synch_noncore_rst_b <= 1'b0;
            synch_uc_rst_b          <= 1'b0;
            cptra_noncore_rst_b     <= 1'b0;
            cptra_uc_rst_b          <= 1'b0;
            wait_count              <= '0;
            iccm_unlock             <= 1'b0;
        end else begin
            boot_fsm_ps <= boot_fsm_ns;

            // first stage, noncore release is sticky once done
            if (propagate_reset_en) begin
                fsm_synch_noncore_rst_b <= 1'b1;
            end
            synch_uc_rst_b <= fsm_synch_uc_rst_b;

            // second stage
            cptra_noncore_rst_b <= fsm_synch_noncore_rst_b;
            // core leaves reset only when both global and fw paths release
            cptra_uc_rst_b <= fsm_synch_noncore_rst_b & fsm_synch_uc_rst_b & synch_uc_rst_b;

            // counter saturates at zero so a zero wait does not wrap
            if (wait_count_decr) begin
                if (wait_count != '0) begin
                    wait_count <= wait_count - 8'd1;
                end
            end else if (wait_count_load) begin
                wait_count <= fw_update_rst_wait_cycles;
            end

            iccm_unlock <= fsm_iccm_unlock;
        end
    end

endmodule

`default_nettype wire

/* hw/soc_ifc_fuse_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "soc_ifc_settings.svh"

module soc_ifc_fuse_regs
    import soc_ifc_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   cptra_rst_b,
    input  axil_req_t                              axil_req,
    input  logic                                   ready_for_fuses,
    input  logic                                   cptra_noncore_rst_b,
    input  logic                                   cptra_uc_rst_b,
    output axil_rsp_t                              axil_rsp,
    output logic                                   fuse_done,
    output logic                                   fw_update_rst,
    output wait_cycles_t                           fw_update_rst_wait_cycles,
    output fuse_word_t [`SOC_IFC_FUSE_WORDS-1:0]   fuse_bank
);

    // index width, at least one bit for a single-word bank
    localparam int FUSE_IDX_W = (`SOC_IFC_FUSE_WORDS > 1) ? $clog2(`SOC_IFC_FUSE_WORDS) : 1;
    // bytes covered by the fuse window
    localparam axil_addr_t FUSE_SPAN = axil_addr_t'(4 * `SOC_IFC_FUSE_WORDS);

    typedef logic [FUSE_IDX_W-1:0] fuse_idx_t;

    // write channel
    logic       wr_ready;
    logic       wr_accept;
    logic       bvalid;
    logic [1:0] bresp;
    logic [1:0] wr_resp_d;
    logic       wr_fuse_hit;
    fuse_idx_t  wr_idx;

    // read channel
    logic       arready;
    logic       rd_accept;
    logic       rvalid;
    axil_data_t rdata;
    logic [1:0] rresp;
    axil_data_t rd_data_d;
    logic [1:0] rd_resp_d;
    logic       rd_fuse_hit;
    fuse_idx_t  rd_idx;

    // aligned address inside the fuse window
    function automatic logic fuse_hit(axil_addr_t addr);
        axil_addr_t offset;
        offset = addr - ADDR_FUSE_BASE;
        return (addr >= ADDR_FUSE_BASE) && (offset < FUSE_SPAN) && (offset[1:0] == 2'b00);
    endfunction

    function automatic fuse_idx_t fuse_idx(axil_addr_t addr);
        axil_addr_t offset;
        offset = addr - ADDR_FUSE_BASE;
        return offset[FUSE_IDX_W+1:2];
    endfunction

    // one of the control registers
    function automatic logic csr_hit(axil_addr_t addr);
        return (addr == ADDR_STATUS) || (addr == ADDR_FUSE_DONE) ||
               (addr == ADDR_FW_UPDATE_RST) || (addr == ADDR_FW_RST_WAIT);
    endfunction

    // byte-wise merge of write data under strobes
    function automatic axil_data_t strb_merge(axil_data_t old_val, axil_data_t new_val,
                                              logic [3:0] strb);
        axil_data_t merged;
        merged = old_val;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return merged;
    endfunction

    assign wr_accept = wr_ready & axil_req.awvalid & axil_req.wvalid;
    assign rd_accept = arready & axil_req.arvalid;

    assign wr_fuse_hit = fuse_hit(axil_req.awaddr);
    assign wr_idx      = fuse_idx(axil_req.awaddr);
    assign rd_fuse_hit = fuse_hit(axil_req.araddr);
    assign rd_idx      = fuse_idx(axil_req.araddr);

    // fuses are locked once the window closes
    always_comb begin
        wr_resp_d = RESP_OKAY;
        if (wr_fuse_hit) begin
            wr_resp_d = ready_for_fuses ? RESP_OKAY : RESP_SLVERR;
        end else if (!csr_hit(axil_req.awaddr)) begin
            wr_resp_d = RESP_SLVERR;
        end
    end

    // read mux, unmapped reads return zero
    always_comb begin
        rd_data_d = '0;
        rd_resp_d = (rd_fuse_hit || csr_hit(axil_req.araddr)) ? RESP_OKAY : RESP_SLVERR;
        if (rd_fuse_hit) begin
            rd_data_d = fuse_bank[rd_idx];
        end else begin
            case (axil_req.araddr)
                ADDR_STATUS: begin
                    rd_data_d = {28'd0, cptra_uc_rst_b, cptra_noncore_rst_b,
                                 fuse_done, ready_for_fuses};
                end
                ADDR_FUSE_DONE:   rd_data_d = {31'd0, fuse_done};
                ADDR_FW_RST_WAIT: rd_data_d = {24'd0, fw_update_rst_wait_cycles};
                default:          rd_data_d = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            wr_ready                  <= 1'b0;
            bvalid                    <= 1'b0;
            fuse_done                 <= 1'b0;
            fw_update_rst             <= 1'b0;
            fw_update_rst_wait_cycles <= `SOC_IFC_FW_RST_WAIT_DEFAULT;
            fuse_bank                 <= '0;
        end else begin
            // single-cycle ready, only with both channels valid and no response pending
            wr_ready      <= axil_req.awvalid & axil_req.wvalid & ~bvalid & ~wr_ready;
            fw_update_rst <= 1'b0;
            if (wr_accept) begin
                bvalid <= 1'b1;
                if (wr_fuse_hit) begin
                    if (ready_for_fuses) begin
                        fuse_bank[wr_idx] <= strb_merge(fuse_bank[wr_idx], axil_req.wdata,
                                                        axil_req.wstrb);
                    end
                end else begin
                    case (axil_req.awaddr)
                        ADDR_FUSE_DONE: begin
                            // sticky until reset
                            if (axil_req.wstrb[0] && axil_req.wdata[0]) begin
                                fuse_done <= 1'b1;
                            end
                        end
                        ADDR_FW_UPDATE_RST: begin
                            if (axil_req.wstrb[0] && axil_req.wdata[0]) begin
                                fw_update_rst <= 1'b1;
                            end
                        end
                        ADDR_FW_RST_WAIT: begin
                            if (axil_req.wstrb[0]) begin
                                fw_update_rst_wait_cycles <= axil_req.wdata[7:0];
                            end
                        end
                        default: begin
                        end
                    endcase
                end
            end else if (bvalid && axil_req.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // read channel, arready drops while a response waits for rready
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else if (rd_accept) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
        end else if (rvalid && axil_req.rready) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
        end else begin
            arready <= ~rvalid;
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= wr_resp_d;
        end
        if (rd_accept) begin
            rdata <= rd_data_d;
            rresp <= rd_resp_d;
        end
    end

    always_comb begin
        axil_rsp.awready = wr_ready;
        axil_rsp.wready  = wr_ready;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.bresp   = bresp;
        axil_rsp.arready = arready;
        axil_rsp.rvalid  = rvalid;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = rresp;
    end

endmodule

`default_nettype wire

/* hw/soc_ifc_boot_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "soc_ifc_settings.svh"

module soc_ifc_boot_top
    import soc_ifc_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 cptra_rst_b,
    input  logic                                 cptra_pwrgood,
    input  axil_req_t                            axil_req,
    output axil_rsp_t                            axil_rsp,
    output fuse_word_t [`SOC_IFC_FUSE_WORDS-1:0] fuse_bank,
    output logic                                 cptra_noncore_rst_b,
    output logic                                 cptra_uc_rst_b,
    output logic                                 iccm_unlock
);

    // register block to boot fsm
    logic         fuse_done;
    logic         fw_update_rst;
    wait_cycles_t fw_update_rst_wait_cycles;
    // boot fsm back to status register
    logic         ready_for_fuses;

    soc_ifc_fuse_regs u_regs (
        .clk                       (clk),
        .cptra_rst_b               (cptra_rst_b),
        .axil_req                  (axil_req),
        .ready_for_fuses           (ready_for_fuses),
        .cptra_noncore_rst_b       (cptra_noncore_rst_b),
        .cptra_uc_rst_b            (cptra_uc_rst_b),
        .axil_rsp                  (axil_rsp),
        .fuse_done                 (fuse_done),
        .fw_update_rst             (fw_update_rst),
        .fw_update_rst_wait_cycles (fw_update_rst_wait_cycles),
        .fuse_bank                 (fuse_bank)
    );

    soc_ifc_boot_fsm u_boot_fsm (
        .clk                       (clk),
        .cptra_rst_b               (cptra_rst_b),
        .cptra_pwrgood             (cptra_pwrgood),
        .fw_update_rst             (fw_update_rst),
        .fw_update_rst_wait_cycles (fw_update_rst_wait_cycles),
        .fuse_done                 (fuse_done),
        .ready_for_fuses           (ready_for_fuses),
        .cptra_noncore_rst_b       (cptra_noncore_rst_b),
        .cptra_uc_rst_b            (cptra_uc_rst_b),
        .iccm_unlock               (iccm_unlock)
    );

endmodule

`default_nettype wire

/* dv/soc_ifc_boot_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "soc_ifc_settings.svh"

module soc_ifc_boot_tb
    import soc_ifc_pkg::*;
();

    localparam int HANDSHAKE_TIMEOUT = 50;
    localparam int FUSE_IDX_W = (`SOC_IFC_FUSE_WORDS > 1) ? $clog2(`SOC_IFC_FUSE_WORDS) : 1;

    logic                                 clk;
    logic                                 cptra_rst_b;
    logic                                 cptra_pwrgood;
    axil_req_t                            axil_req;
    axil_rsp_t                            axil_rsp;
    fuse_word_t [`SOC_IFC_FUSE_WORDS-1:0] fuse_bank;
    logic                                 cptra_noncore_rst_b;
    logic                                 cptra_uc_rst_b;
    logic                                 iccm_unlock;

    // free running cycle count, read only at falling edges
    int   cycle_cnt = 0;
    // cycle stamp of the last accepted write
    int   wr_accept_cycle;
    // set while a firmware-update reset is expected to pulse iccm_unlock
    logic fw_check_active;
    int   fd;
    logic [8*128-1:0] comment_line;

    soc_ifc_boot_top u_dut (
        .clk                 (clk),
        .cptra_rst_b         (cptra_rst_b),
        .cptra_pwrgood       (cptra_pwrgood),
        .axil_req            (axil_req),
        .axil_rsp            (axil_rsp),
        .fuse_bank           (fuse_bank),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .cptra_uc_rst_b      (cptra_uc_rst_b),
        .iccm_unlock         (iccm_unlock)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("Error at %0t: %s, got %h, expected %h",
                                $time, what, actual, expected));
        end
    endtask

    // unlock pulses are only legal inside a firmware-update reset
    always @(negedge clk) begin
        if (cptra_rst_b && !fw_check_active && iccm_unlock) begin
            abort_run("iccm_unlock pulsed outside a firmware-update reset");
        end
    end

    // port index as used in the case file
    function automatic logic port_value(input logic [31:0] idx);
        case (idx)
            32'd0:   return cptra_noncore_rst_b;
            32'd1:   return cptra_uc_rst_b;
            default: return iccm_unlock;
        endcase
    endfunction

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              input logic [3:0] strb, output logic [1:0] resp);
        int cnt;
        @(posedge clk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= strb;
        axil_req.bready  <= 1'b1;
        cnt = 0;
        @(negedge clk);
        while (!axil_rsp.awready) begin
            cnt++;
            if (cnt > HANDSHAKE_TIMEOUT) begin
                abort_run("Timeout waiting for awready and wready");
            end
            @(negedge clk);
        end
        // both write channels are accepted together
        check_value(32'(axil_rsp.wready), 32'd1, "wready together with awready");
        // address and data are taken on this edge
        @(posedge clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        @(negedge clk);
        wr_accept_cycle = cycle_cnt;
        cnt = 0;
        while (!axil_rsp.bvalid) begin
            cnt++;
            if (cnt > HANDSHAKE_TIMEOUT) begin
                abort_run("Timeout waiting for bvalid");
            end
            @(negedge clk);
        end
        resp = axil_rsp.bresp;
        // bready is high, response retires here
        @(posedge clk);
        axil_req.bready <= 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                             output logic [1:0] resp);
        int cnt;
        @(posedge clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        axil_req.rready  <= 1'b1;
        cnt = 0;
        @(negedge clk);
        while (!axil_rsp.arready) begin
            cnt++;
            if (cnt > HANDSHAKE_TIMEOUT) begin
                abort_run("Timeout waiting for arready");
            end
            @(negedge clk);
        end
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        @(negedge clk);
        cnt = 0;
        while (!axil_rsp.rvalid) begin
            cnt++;
            if (cnt > HANDSHAKE_TIMEOUT) begin
                abort_run("Timeout waiting for rvalid");
            end
            @(negedge clk);
        end
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        @(posedge clk);
        axil_req.rready <= 1'b0;
    endtask

    task automatic wait_port(input logic [31:0] idx, input logic level,
                             input logic [31:0] limit);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (port_value(idx) !== level) begin
            cnt++;
            if (cnt > int'(limit)) begin
                abort_run($sformatf("Timeout waiting for port %0d to reach level %0d",
                                    idx, level));
            end
            @(negedge clk);
        end
    endtask

    // request a core-only reset and watch it through to the unlock pulse
    task automatic fw_update_check(input wait_cycles_t n);
        int         cnt;
        int         unlocks;
        int         unlock_at;
        int         latency;
        logic       uc_low_seen;
        logic       uc_back;
        logic [1:0] resp;
        unlocks     = 0;
        unlock_at   = 0;
        uc_low_seen = 1'b0;
        uc_back     = 1'b0;
        @(posedge clk);
        fw_check_active = 1'b1;
        axil_write(ADDR_FW_UPDATE_RST, 32'd1, 4'h1, resp);
        check_value(32'(resp), 32'(RESP_OKAY), "firmware-update request response");
        cnt = 0;
        while (!uc_back) begin
            @(negedge clk);
            cnt++;
            if (cnt > int'(n) + 20) begin
                abort_run("Timeout waiting for the firmware-update reset to finish");
            end
            check_value(32'(cptra_noncore_rst_b), 32'd1, "noncore reset during fw update");
            if (!cptra_uc_rst_b) begin
                uc_low_seen = 1'b1;
            end
            if (iccm_unlock) begin
                unlocks++;
                unlock_at = cycle_cnt;
                check_value(32'(cptra_uc_rst_b), 32'd0, "uc reset at iccm unlock");
            end
            if (cptra_uc_rst_b && unlocks > 0) begin
                uc_back = 1'b1;
            end
        end
        // no late second pulse
        repeat (4) begin
            @(negedge clk);
            check_value(32'(iccm_unlock), 32'd0, "extra iccm unlock pulse");
        end
        @(posedge clk);
        fw_check_active = 1'b0;
        check_value(32'(unlocks), 32'd1, "iccm unlock pulse count");
        check_value(32'(uc_low_seen), 32'd1, "uc reset asserted during fw update");
        latency = unlock_at - wr_accept_cycle;
        check_value(32'((latency >= int'(n)) && (latency <= int'(n) + 4)), 32'd1,
                    $sformatf("request to unlock latency %0d for wait %0d", latency, n));
    endtask

    task automatic expect_fields(input int code, input int count);
        if (code != count) begin
            abort_run("Malformed line in the case file");
        end
    endtask

    task automatic run_case(input logic [7:0] op);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [1:0]  resp;
        axil_data_t  rd;
        int          code;
        if (op == "#") begin
            code = $fgets(comment_line, fd);
        end else if (op == "W") begin
            code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
            expect_fields(code, 4);
            axil_write(axil_addr_t'(a), b, c[3:0], resp);
            check_value(32'(resp), d, $sformatf("write response at %h", a[11:0]));
        end else if (op == "R") begin
            code = $fscanf(fd, "%h %h %h", a, b, c);
            expect_fields(code, 3);
            axil_read(axil_addr_t'(a), rd, resp);
            check_value(rd, b, $sformatf("read data at %h", a[11:0]));
            check_value(32'(resp), c, $sformatf("read response at %h", a[11:0]));
        end else if (op == "P") begin
            code = $fscanf(fd, "%h %h %h", a, b, c);
            expect_fields(code, 3);
            wait_port(a, b[0], c);
        end else if (op == "B") begin
            code = $fscanf(fd, "%h %h", a, b);
            expect_fields(code, 2);
            @(negedge clk);
            check_value(fuse_bank[a[FUSE_IDX_W-1:0]], b, $sformatf("fuse_bank word %0d", a));
        end else if (op == "F") begin
            code = $fscanf(fd, "%h", a);
            expect_fields(code, 1);
            fw_update_check(a[7:0]);
        end else begin
            abort_run("Unknown operation in the case file");
        end
    endtask

    initial begin
        logic [7:0] op;
        int         code;
        logic       done;
        fw_check_active = 1'b0;
        cptra_rst_b     = 1'b0;
        cptra_pwrgood   = 1'b0;
        axil_req        = '0;
        // outputs while reset is held
        @(posedge clk);
        @(negedge clk);
        check_value(32'(cptra_noncore_rst_b), 32'd0, "noncore reset in reset");
        check_value(32'(cptra_uc_rst_b), 32'd0, "uc reset in reset");
        check_value(32'(iccm_unlock), 32'd0, "iccm unlock in reset");
        check_value(32'(axil_rsp.awready), 32'd0, "awready in reset");
        check_value(32'(axil_rsp.wready), 32'd0, "wready in reset");
        check_value(32'(axil_rsp.bvalid), 32'd0, "bvalid in reset");
        check_value(32'(axil_rsp.arready), 32'd0, "arready in reset");
        check_value(32'(axil_rsp.rvalid), 32'd0, "rvalid in reset");
        @(posedge clk);
        cptra_rst_b <= 1'b1;
        @(negedge clk);
        check_value(32'(cptra_noncore_rst_b), 32'd0, "noncore reset after release");
        check_value(32'(cptra_uc_rst_b), 32'd0, "uc reset after release");
        check_value(32'(iccm_unlock), 32'd0, "iccm unlock after release");
        @(posedge clk);
        cptra_pwrgood <= 1'b1;
        @(negedge clk);
        // arready comes up one cycle after reset
        check_value(32'(axil_rsp.arready), 32'd1, "arready after reset");

        fd = $fopen("dv/soc_ifc_boot_cases.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open dv/soc_ifc_boot_cases.txt");
        end
        done = 1'b0;
        while (!done) begin
            op   = 8'd0;
            code = $fscanf(fd, "%s", op);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                run_case(op);
            end
        end
        $fclose(fd);

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* soc_ifc_boot.f */
+incdir+hw
hw/soc_ifc_pkg.sv
hw/soc_ifc_boot_fsm.sv
hw/soc_ifc_fuse_regs.sv
hw/soc_ifc_boot_top.sv
dv/soc_ifc_boot_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator and run it
# the exit status of the simulation is the result
cd "$(dirname "$0")" &&
verilator --binary --timing \
    -f soc_ifc_boot.f \
    --top-module soc_ifc_boot_tb \
    --Mdir obj_dir \
    -o soc_ifc_boot_sim &&
./obj_dir/soc_ifc_boot_sim ||
{ echo "simulation build or run failed"; exit 1; }

/* dv/soc_ifc_boot_cases.txt */
# W addr data strb resp | R addr data resp | P port level timeout | B word data | F wait
# all fields hex, ports 0 noncore reset 1 uc reset 2 iccm unlock, resp 0 okay 2 slverr
R 000 00000001 0
W 100 11223344 f 0
W 104 aabbccdd f 0
W 104 55667788 5 0
W 108 deadbeef 8 0
W 10c 0f0f0f0f 6 0
R 100 11223344 0
R 104 aa66cc88 0
R 108 de000000 0
R 10c 000f0f00 0
B 0 11223344
B 1 aa66cc88
B 2 de000000
B 3 000f0f00
W 004 00000001 1 0
P 0 1 20
P 1 1 20
R 000 0000000e 0
W 104 ffffffff f 2
R 104 aa66cc88 0
B 1 aa66cc88
W 200 12345678 f 2
R 200 00000000 2
R 102 00000000 2
R 00c 00000014 0
W 00c 00000005 1 0
R 00c 00000005 0
R 008 00000000 0
F 5
R 000 0000000e 0
W 00c 00000000 1 0
F 0
W 00c 00000021 1 0
R 00c 00000021 0
F 21
R 000 0000000e 0
